//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = compress_window_tb
FILELIST  = compile.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/compress_window_chk.sv
////////////////////////////////////////////////////////////////////////////
// Credit and reset assertions for bin_buffer, attached with bind
////////////////////////////////////////////////////////////////////////////
module compress_window_chk #(
    parameter int credits_init = 2,
    parameter int cred_w       = 2
) (
    input logic              clk,
    input logic              rstn,
    input logic              row_valid,
    input logic              overflow,
    input logic [cred_w-1:0] credits
);

    // A row on the wire still holds its credit
    a_valid_credit: assert property (@(posedge clk) disable iff (!rstn)
        row_valid |-> credits != '0)
        else $error("row_valid fired with zero credits");

    a_credit_cap: assert property (@(posedge clk) disable iff (!rstn)
        credits <= cred_w'(credits_init))
        else $error("credit count above its reset value");

    a_reset_quiet: assert property (@(posedge clk)
        !rstn |-> !row_valid && !overflow)
        else $error("row_valid or overflow high during reset");

endmodule : compress_window_chk

bind bin_buffer compress_window_chk #(
    .credits_init (credits_init),
    .cred_w       (cred_w)
) u_chk (
    .clk       (clk),
    .rstn      (rstn),
    .row_valid (row_valid),
    .overflow  (overflow),
    .credits   (credits)
);

//--- bench/compress_window_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for compress_window with test table, tile reference model,
// row, pixel and flag compare tasks, credit return and watchdog
////////////////////////////////////////////////////////////////////////////
module compress_window_tb import video_pkg::*; ();

    localparam int h_act        = 64;
    localparam int v_act        = 40;
    localparam int buf_depth    = 4;
    localparam int credits_init = 2;
    localparam int n_tiles      = h_act / tile_w;
    localparam int h_blank      = 16;
    localparam int vs_len       = 4;
    localparam int frame_cycles = 2 * vs_len + v_act * (h_act + h_blank);
    localparam int n_tests      = 6;

    localparam logic [1:0] win_const = 2'd0;
    localparam logic [1:0] win_rand  = 2'd1;
    localparam logic [1:0] win_cols  = 2'd2;
    localparam logic [7:0] hold_all  = 8'd255;  // Credits only after the last frame

    typedef struct packed {
        logic [1:0] win_mode;
        logic [4:0] win_val;
        logic [1:0] frames;
        logic [7:0] hold_rows;  // Commits before credits flow
        logic       exp_ovf;
    } test_t;

    test_t tests [n_tests] = '{
        '{win_const, 5'b00011, 2'd1, 8'd0, 1'b0},
        '{win_const, 5'b00111, 2'd1, 8'd0, 1'b0},
        '{win_rand,  5'b00000, 2'd2, 8'd0, 1'b0},
        '{win_rand,  5'b00000, 2'd2, hold_all, 1'b1},
        '{win_cols,  5'b00000, 2'd1, 8'd0, 1'b0},
        '{win_rand,  5'b00000, 2'd1, 8'd4, 1'b0}
    };
    string names [n_tests] = '{"thresh_low", "thresh_high", "random", "overflow",
                               "col_pattern", "credit_hold"};

    logic             clk;
    logic             rstn;
    pixel_t           pix_in;
    logic [win_w-1:0] window;
    pixel_t           pix_out;
    bin_row_t         row_out;
    logic             row_valid;
    logic             row_credit;
    logic             overflow;

    int       seed = 32'h94d5_a957;
    int       errors;
    int       pushed;
    int       received;
    int       owed;
    int       commits;
    int       row_limit;
    bit       gate;
    bit       prev_valid;
    bit       prev_rgb;
    pixel_t   prev_exp;
    string    cur_name;
    bin_row_t exp_rows [$];

    compress_window #(
        .h_act        (h_act),
        .v_act        (v_act),
        .buf_depth    (buf_depth),
        .credits_init (credits_init)
    ) DUT (
        .clk        (clk),
        .rstn       (rstn),
        .pix_in     (pix_in),
        .window     (window),
        .pix_out    (pix_out),
        .row_out    (row_out),
        .row_valid  (row_valid),
        .row_credit (row_credit),
        .overflow   (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare_row(input bin_row_t exp, input bin_row_t act);
        if (exp !== act) begin
            errors++;
            $display("error %s: row expected %h actual %h", cur_name, exp, act);
        end
    endtask

    task automatic compare_pix(input pixel_t exp, input pixel_t act, input bit with_rgb);
        pixel_t masked;
        masked = act;
        if (!with_rgb) begin  // Colour not defined here
            masked.r = exp.r;
            masked.g = exp.g;
            masked.b = exp.b;
        end
        if (exp !== masked) begin
            errors++;
            $display("error %s: pixel expected %h actual %h", cur_name, exp, act);
        end
    endtask

    task automatic compare_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("error %s: %s expected %b actual %b", cur_name, what, exp, act);
        end
    endtask

    function automatic logic [win_w-1:0] window_value(input test_t t, input int x,
                                                      input int trow, input bit de);
        case (t.win_mode)
            win_const: return t.win_val;
            win_rand:  return win_w'($random(seed));
            default: begin
                if (de && x % tile_w < samp_cols) begin
                    return ((x / tile_w + trow) % 2 != 0) ? 5'b00111 : 5'b00011;
                end
                return 5'b11111;  // Unsampled columns flip every tile if counted
            end
        endcase
    endfunction

    // Consumer owes one credit per row
    always @(negedge clk) begin
        if (rstn && row_valid) begin
            if (exp_rows.size() == 0) begin
                errors++;
                $display("%s: a row was sent that was never committed", cur_name);
            end else begin
                compare_row(exp_rows.pop_front(), row_out);
            end
            received++;
            owed++;
        end
    end

    initial begin
        row_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (gate && owed > 0) begin
                row_credit = 1'b1;
                owed--;
            end else begin
                row_credit = 1'b0;
            end
        end
    end

    task automatic apply_reset();
        rstn       = 1'b0;
        pix_in     = '0;
        window     = '0;
        gate       = 1'b0;
        owed       = 0;
        pushed     = 0;
        received   = 0;
        commits    = 0;
        prev_valid = 1'b0;
        exp_rows.delete();
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        compare_flag("row_valid after reset", 1'b0, row_valid);
        compare_flag("overflow after reset", 1'b0, overflow);
        @(negedge clk);
        owed = 1;  // Spare credit while the counter is full
        gate = 1'b1;
        @(negedge clk);
        gate = 1'b0;
    endtask

    task automatic open_credits();
        if (!gate) begin
            if (received > credits_init) begin
                errors++;
                $display("%s: %0d rows sent without returned credits", cur_name, received);
            end
            gate = 1'b1;
        end
    endtask

    task automatic commit_row(input test_t t, input bin_row_t row);
        commits++;
        if (commits <= row_limit) begin
            exp_rows.push_back(row);
            pushed++;
        end
        if (commits >= int'(t.hold_rows)) open_credits();
    endtask

    // Checks the previous pixel and drives the next
    task automatic drive_pixel(input pixel_t p, input logic [win_w-1:0] w,
                               input bit with_rgb, input logic lvl);
        @(posedge clk);
        #1;
        if (prev_valid) compare_pix(prev_exp, pix_out, prev_rgb);
        pix_in     = p;
        window     = w;
        prev_exp   = p;
        prev_exp.r = lvl ? 8'hff : 8'h00;
        prev_exp.g = prev_exp.r;
        prev_exp.b = prev_exp.r;
        prev_rgb   = with_rgb;
        prev_valid = 1'b1;
    endtask

    task automatic drive_frame(input test_t t);
        pixel_t             p;
        logic [win_w-1:0]   w;
        int                 sums [n_tiles];
        logic [n_tiles-1:0] bits;
        bin_row_t           row;
        int                 phase;
        int                 trow;
        bit                 with_rgb;
        logic               lvl;
        bits = '0;
        for (int i = 0; i < 2 * vs_len; i++) begin
            p       = '0;
            p.vsync = (i < vs_len);
            drive_pixel(p, window_value(t, 0, 0, 1'b0), 1'b0, 1'b0);
        end
        for (int y = 0; y < v_act; y++) begin
            phase = y % tile_h;
            trow  = y / tile_h;
            for (int x = 0; x < h_act + h_blank; x++) begin
                p       = '0;
                p.de    = (x < h_act);
                p.hsync = (x >= h_act + 4) && (x < h_act + 12);
                p.x     = coord_w'(x);
                p.y     = coord_w'(y);
                w       = window_value(t, x, trow, p.de);
                if (p.de && phase == samp_line && x % tile_w < samp_cols) begin
                    if (x % tile_w == 0) sums[x / tile_w] = 0;
                    sums[x / tile_w] += $countones(w);
                    bits[x / tile_w] = (sums[x / tile_w] >= sum_thresh);
                end
                if (x == h_act && phase == samp_line) begin  // Commit cycle
                    row                   = '0;
                    row.row_idx           = 8'(trow);
                    row.bits[n_tiles-1:0] = bits;
                    commit_row(t, row);
                end
                with_rgb = p.de && phase >= samp_line && x >= samp_cols - 1;
                lvl      = 1'b0;
                if (with_rgb) lvl = bits[(x - samp_cols + 1) / tile_w];
                drive_pixel(p, w, with_rgb, lvl);
            end
            if (phase == samp_line && t.hold_rows == 8'd0 && received != pushed) begin
                errors++;
                $display("%s: row %0d was not sent within the line blanking", cur_name, trow);
            end
        end
    endtask

    task automatic run_test(input test_t t);
        int wait_cycles;
        row_limit = (t.hold_rows == hold_all) ? credits_init + buf_depth : 1 << 30;
        gate      = (t.hold_rows == 8'd0);
        for (int f = 0; f < int'(t.frames); f++) begin
            drive_frame(t);
            compare_flag("overflow after frame", 1'(commits > row_limit), overflow);
        end
        open_credits();
        wait_cycles = 0;
        while (received < pushed && wait_cycles < 200) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (received < pushed) begin
            errors++;
            $display("%s: only %0d of %0d rows arrived", cur_name, received, pushed);
        end
        compare_flag("overflow at end", t.exp_ovf, overflow);
    endtask

    initial begin
        int total;
        total = 0;
        for (int i = 0; i < n_tests; i++) total += int'(tests[i].frames);
        #((total * frame_cycles + n_tests * 500) * 8);
        $display("timeout: the tests did not finish in the expected time");
        $display("Errors found");
        $finish;
    end

    initial begin
        int start_err;
        int n_fail;
        rstn   = 1'b0;
        pix_in = '0;
        window = '0;
        n_fail = 0;
        for (int i = 0; i < n_tests; i++) begin
            cur_name  = names[i];
            start_err = errors;
            apply_reset();
            run_test(tests[i]);
            if (errors == start_err) begin
                $display("test %s: pass", names[i]);
            end else begin
                n_fail++;
                $display("test %s: fail with %0d errors", names[i], errors - start_err);
            end
        end
        $display("tests %0d, failed %0d, errors %0d", n_tests, n_fail, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : compress_window_tb

//--- compile.f
hw/video_pkg.sv
hw/tile_counter.sv
hw/window_fsm.sv
hw/window_accum.sv
hw/bin_buffer.sv
hw/debug_overlay.sv
hw/compress_window.sv
bench/compress_window_chk.sv
bench/compress_window_tb.sv

//--- hw/bin_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Row word assembly, row queue and credit-based send logic
////////////////////////////////////////////////////////////////////////////
module bin_buffer import video_pkg::*; #(
    parameter int h_act        = 1280,
    parameter int v_act        = 720,
    parameter int buf_depth    = 4,
    parameter int credits_init = 2
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     vsync,
    input  logic     tile_done,
    input  logic     tile_bit,
    input  logic     commit,
    input  logic     row_credit,
    output bin_row_t row_out,
    output logic     row_valid,
    output logic     overflow
);

    localparam int n_tiles = h_act / tile_w;
    localparam int n_rows  = v_act / tile_h;
    localparam int ptr_w   = (buf_depth > 1) ? $clog2(buf_depth) : 1;
    localparam int cnt_w   = $clog2(buf_depth + 1);
    localparam int cred_w  = $clog2(credits_init + 1);

    logic [7:0]           tile_idx;
    logic [7:0]           row_idx;
    logic [max_tiles-1:0] row_bits;

    bin_row_t             queue [buf_depth];
    logic [ptr_w-1:0]     wr_ptr;
    logic [ptr_w-1:0]     rd_ptr;
    logic [cnt_w-1:0]     count;
    logic [cred_w-1:0]    credits;
    logic [cred_w-1:0]    credits_free;
    logic                 push;
    logic                 send;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(buf_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // Index wraps per line, so every line starts at tile 0
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tile_idx <= '0;
            row_idx  <= '0;
            row_bits <= '0;
        end else if (vsync) begin
            tile_idx <= '0;
            row_idx  <= '0;
            row_bits <= '0;
        end else begin
            if (tile_done) begin
                row_bits[tile_idx] <= tile_bit;
                tile_idx <= (tile_idx == 8'(n_tiles - 1)) ? 8'd0 : tile_idx + 8'd1;
            end
            if (commit) begin
                row_idx <= (row_idx == 8'(n_rows - 1)) ? 8'd0 : row_idx + 8'd1;
            end
        end
    end

    // Credit of a row on the wire is already spent
    assign credits_free = credits - cred_w'(row_valid);
    assign push         = commit && (count != cnt_w'(buf_depth));
    assign send         = (count != '0) && (credits_free != '0);

    always_ff @(posedge clk) begin
        if (push) queue[wr_ptr] <= '{row_idx: row_idx, bits: row_bits};
    end

    always_ff @(posedge clk) begin
        if (send) row_out <= queue[rd_ptr];
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            row_valid <= 1'b0;
            overflow  <= 1'b0;
            credits   <= cred_w'(credits_init);
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (send) rd_ptr <= next_ptr(rd_ptr);
            count     <= count + cnt_w'(push) - cnt_w'(send);
            row_valid <= send;
            if (commit && !push) overflow <= 1'b1;  // Sticky until reset
            if (row_credit && credits_free < cred_w'(credits_init)) begin
                credits <= credits_free + 1'b1;
            end else begin
                credits <= credits_free;
            end
        end
    end

endmodule : bin_buffer

//--- hw/compress_window.sv
////////////////////////////////////////////////////////////////////////////
// Tile window compression top, binarized row output and debug video
////////////////////////////////////////////////////////////////////////////
module compress_window import video_pkg::*; #(
    parameter int h_act        = 1280,
    parameter int v_act        = 720,
    parameter int buf_depth    = 4,
    parameter int credits_init = 2
) (
    input  logic             clk,
    input  logic             rstn,
    input  pixel_t           pix_in,
    input  logic [win_w-1:0] window,
    output pixel_t           pix_out,
    output bin_row_t         row_out,
    output logic             row_valid,
    input  logic             row_credit,
    output logic             overflow
);

    logic       col_en;
    logic [3:0] line_phase;
    logic       tile_done;
    logic       line_end;
    logic       accum_en;
    logic       commit;
    logic       record;
    logic       replay;
    logic       tile_bit;

    tile_counter u_tile_counter (
        .clk        (clk),
        .rstn       (rstn),
        .pix        (pix_in),
        .col_phase  (),         // Only needed for tile_done
        .col_en     (col_en),
        .line_phase (line_phase),
        .tile_done  (tile_done),
        .line_end   (line_end)
    );

    window_fsm u_window_fsm (
        .clk        (clk),
        .rstn       (rstn),
        .pix        (pix_in),
        .line_phase (line_phase),
        .line_end   (line_end),
        .accum_en   (accum_en),
        .commit     (commit),
        .record     (record),
        .replay     (replay)
    );

    window_accum u_window_accum (
        .clk        (clk),
        .rstn       (rstn),
        .window     (window),
        .accum_en   (accum_en),
        .col_en     (col_en),
        .tile_done  (tile_done),
        .de         (pix_in.de),
        .tile_bit   (tile_bit)
    );

    bin_buffer #(
        .h_act        (h_act),
        .v_act        (v_act),
        .buf_depth    (buf_depth),
        .credits_init (credits_init)
    ) u_bin_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .vsync      (pix_in.vsync),
        .tile_done  (tile_done),
        .tile_bit   (tile_bit),
        .commit     (commit),
        .row_credit (row_credit),
        .row_out    (row_out),
        .row_valid  (row_valid),
        .overflow   (overflow)
    );

    debug_overlay #(
        .h_act (h_act)
    ) u_debug_overlay (
        .clk       (clk),
        .rstn      (rstn),
        .pix       (pix_in),
        .record    (record),
        .replay    (replay),
        .tile_done (tile_done),
        .tile_bit  (tile_bit),
        .pix_out   (pix_out)
    );

endmodule : compress_window

//--- hw/debug_overlay.sv
////////////////////////////////////////////////////////////////////////////
// Tile bit line store and black/white debug pixel output
////////////////////////////////////////////////////////////////////////////
module debug_overlay import video_pkg::*; #(
    parameter int h_act = 1280
) (
    input  logic   clk,
    input  logic   rstn,
    input  pixel_t pix,
    input  logic   record,
    input  logic   replay,
    input  logic   tile_done,
    input  logic   tile_bit,
    output pixel_t pix_out
);

    localparam int n_tiles = h_act / tile_w;
    localparam int addr_w  = (n_tiles > 1) ? $clog2(n_tiles) : 1;

    logic [n_tiles-1:0] line_bits;
    logic [addr_w-1:0]  addr;
    logic               shown;
    logic               cur_bit;
    logic [7:0]         level;
    pixel_t             pix_dbg;

    always_comb begin
        cur_bit = shown;  // Held between tile updates
        if (tile_done && record) begin
            cur_bit = tile_bit;
        end else if (tile_done && replay) begin
            cur_bit = line_bits[addr];
        end
    end

    assign level = cur_bit ? 8'hff : 8'h00;

    always_comb begin
        pix_dbg   = pix;
        pix_dbg.r = level;
        pix_dbg.g = level;
        pix_dbg.b = level;
    end

    always_ff @(posedge clk) begin
        if (tile_done && record) line_bits[addr] <= tile_bit;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr    <= '0;
            shown   <= 1'b0;
            pix_out <= '0;
        end else begin
            shown   <= cur_bit;
            pix_out <= pix_dbg;
            if (!pix.de) begin
                addr <= '0;
            end else if (tile_done) begin
                addr <= (addr == addr_w'(n_tiles - 1)) ? '0 : addr + 1'b1;
            end
        end
    end

endmodule : debug_overlay

//--- hw/tile_counter.sv
////////////////////////////////////////////////////////////////////////////
// Column and line phase counters inside a tile, tile and line strobes
////////////////////////////////////////////////////////////////////////////
module tile_counter import video_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  pixel_t     pix,
    output logic [2:0] col_phase,
    output logic       col_en,
    output logic [3:0] line_phase,
    output logic       tile_done,
    output logic       line_end
);

    logic de_d;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            de_d <= 1'b0;
        end else begin
            de_d <= pix.de;
        end
    end

    assign line_end = de_d & ~pix.de;

    // col_en is high on the first half of each tile
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            col_phase <= '0;
            col_en    <= 1'b1;
        end else if (pix.vsync || !pix.de) begin
            col_phase <= '0;
            col_en    <= 1'b1;
        end else if (col_phase == 3'(samp_cols - 1)) begin
            col_phase <= '0;
            col_en    <= ~col_en;
        end else begin
            col_phase <= col_phase + 3'd1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            line_phase <= '0;
        end else if (pix.vsync) begin
            line_phase <= '0;
        end else if (line_end) begin
            if (line_phase == 4'(tile_h - 1)) begin
                line_phase <= '0;
            end else begin
                line_phase <= line_phase + 4'd1;
            end
        end
    end

    assign tile_done = pix.de & col_en & (col_phase == 3'(samp_cols - 1));

endmodule : tile_counter

//--- hw/video_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Pixel and row word types, tile geometry and threshold constants
////////////////////////////////////////////////////////////////////////////
package video_pkg;

    localparam int coord_w = 12;

    typedef struct packed {
        logic               hsync;
        logic               vsync;
        logic               de;
        logic [7:0]         r;
        logic [7:0]         g;
        logic [7:0]         b;
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
    } pixel_t;

    // Tile geometry
    localparam int tile_w    = 16;
    localparam int tile_h    = 10;
    localparam int samp_cols = 8;  // Sampled columns at tile start
    localparam int samp_line = 4;  // Sampled line within a tile

    localparam int win_w      = 5;
    localparam int sum_thresh = 20;  // Half of the 8x5 window
    localparam int max_tiles  = 256;

    typedef struct packed {
        logic [7:0]           row_idx;
        logic [max_tiles-1:0] bits;  // Bit i is tile column i
    } bin_row_t;

endpackage : video_pkg

//--- hw/window_accum.sv
////////////////////////////////////////////////////////////////////////////
// Window popcount accumulation over 8 columns and tile threshold
////////////////////////////////////////////////////////////////////////////
module window_accum import video_pkg::*; (
    input  logic             clk,
    input  logic             rstn,
    input  logic [win_w-1:0] window,
    input  logic             accum_en,
    input  logic             col_en,
    input  logic             tile_done,
    input  logic             de,
    output logic             tile_bit
);

    logic [2:0] pop;    // Max 5
    logic [5:0] sum;    // Max 40
    logic [5:0] total;

    always_comb begin
        pop = '0;
        for (int i = 0; i < win_w; i++) begin
            pop = pop + 3'(window[i]);
        end
    end

    assign total = sum + 6'(pop);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sum <= '0;
        end else if (accum_en && col_en && de) begin
            sum <= total;
        end else begin
            sum <= '0;
        end
    end

    // Includes the last column of the window
    assign tile_bit = tile_done & (total >= 6'(sum_thresh));

endmodule : window_accum

//--- hw/window_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Per-line FSM for accumulation, row commit and overlay mode
////////////////////////////////////////////////////////////////////////////
module window_fsm import video_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  pixel_t     pix,
    input  logic [3:0] line_phase,
    input  logic       line_end,
    output logic       accum_en,
    output logic       commit,
    output logic       record,
    output logic       replay
);

    typedef enum logic [1:0] {
        frame_wait,
        skip_line,
        sample_line,
        replay_line
    } state_t;

    state_t     state;
    state_t     line_state;
    logic       vsync_d;
    logic [3:0] next_phase;

    // Phase of the line that starts after line_end
    assign next_phase = (line_phase == 4'(tile_h - 1)) ? 4'd0 : line_phase + 4'd1;

    always_comb begin
        if (next_phase == 4'(samp_line)) begin
            line_state = sample_line;
        end else if (next_phase > 4'(samp_line)) begin
            line_state = replay_line;
        end else begin
            line_state = skip_line;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= frame_wait;
            vsync_d <= 1'b0;
        end else begin
            vsync_d <= pix.vsync;
            if (pix.vsync) begin
                state <= frame_wait;
            end else if (state == frame_wait) begin
                if (vsync_d) state <= skip_line;  // Falling vsync, line 0 next
            end else if (line_end) begin
                state <= line_state;
            end
        end
    end

    assign accum_en = (state == sample_line);
    assign record   = (state == sample_line);
    assign commit   = (state == sample_line) & line_end;
    assign replay   = (state == replay_line);

endmodule : window_fsm
